// ==== roce_pktgen.f ====
common/roce_hdr_pkg.sv
common/pktgen_cfg_pkg.sv
common/beat_stream_if.sv
common/pktgen_cfg_if.sv
hdl/wb_cfg_regs.sv
pkt_gen/roce_hdr_builder.sv
pkt_gen/payload_gen.sv
pkt_gen/frame_merge.sv
hdl/roce_pktgen_top.sv
dv/roce_pktgen_asserts.sv
dv/roce_pktgen_tb.sv

// ==== Bender.yml ====
package:
  name: roce_pktgen

sources:
  - common/roce_hdr_pkg.sv
  - common/pktgen_cfg_pkg.sv
  - common/beat_stream_if.sv
  - common/pktgen_cfg_if.sv
  - hdl/wb_cfg_regs.sv
  - pkt_gen/roce_hdr_builder.sv
  - pkt_gen/payload_gen.sv
  - pkt_gen/frame_merge.sv
  - hdl/roce_pktgen_top.sv
  - target: test
    files:
      - dv/roce_pktgen_asserts.sv
      - dv/roce_pktgen_tb.sv

// ==== dv/roce_pktgen_tb.sv ====
`default_nettype none

module roce_pktgen_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import pktgen_cfg_pkg::*;

    localparam int MAX_BEATS   = 16;
    // 1x11, 5x10, 4x24, 2x9 plus 2x24, 3x12 beats
    localparam int TOTAL_BEATS = 11 + 50 + 96 + 66 + 36;
    localparam int CYCLE_LIMIT = 20 * TOTAL_BEATS + 2000;

    logic        aclk;
    logic        aresetn;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [5:0]  wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;
    logic [63:0] tx_tdata;
    logic [7:0]  tx_tkeep;
    logic        tx_tvalid;
    logic        tx_tlast;
    logic        tx_tready;

    integer      seed;
    int          cycle_cnt;
    logic        rand_ready;
    logic [72:0] rx_q[$];   // {last, keep, data}
    logic [7:0]  frame[$];

    logic [47:0] m_src_mac;
    logic [47:0] m_dst_mac;
    logic [31:0] m_src_ip;
    logic [31:0] m_dst_ip;
    logic [23:0] m_qp;
    logic [23:0] m_psn;
    int          m_pb;

    roce_pktgen_top #(
        .MAX_PAYLOAD_BEATS (MAX_BEATS)
    ) UUT (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .i_wb_cyc    (wb_cyc),
        .i_wb_stb    (wb_stb),
        .i_wb_we     (wb_we),
        .i_wb_adr    (wb_adr),
        .i_wb_dat    (wb_dat_w),
        .o_wb_dat    (wb_dat_r),
        .o_wb_ack    (wb_ack),
        .o_tx_tdata  (tx_tdata),
        .o_tx_tkeep  (tx_tkeep),
        .o_tx_tvalid (tx_tvalid),
        .o_tx_tlast  (tx_tlast),
        .i_tx_tready (tx_tready)
    );

    always #50 aclk = ~aclk;

    always @(posedge aclk) begin
        cycle_cnt++;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout: run did not complete within %0d cycles", CYCLE_LIMIT);
            $display("Simulation finished: FAIL");
            $fatal(1, "timeout");
        end
    end

    always @(negedge aclk) begin
        if (UUT.u_asserts.fail_cnt != 0) begin
            $display("Assertion failure in the bound checker at %0t ns", $time);
            $display("Simulation finished: FAIL");
            $fatal(1, "assertion failed");
        end
    end

    // Sink side, ready and capture on the falling edge
    always @(negedge aclk) begin
        if (rand_ready) begin
            tx_tready = ($random(seed) % 2) != 0;
        end else begin
            tx_tready = 1'b1;
        end
        if (tx_tvalid && tx_tready) begin
            rx_q.push_back({tx_tlast, tx_tkeep, tx_tdata});
        end
    end

    task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
            $display("Simulation finished: FAIL");
            $fatal(1, "check failed");
        end
    endtask

    task automatic bus_cycle(input logic we, input logic [3:0] idx, input logic [31:0] wdat,
                             output logic [31:0] rdat);
        @(negedge aclk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = {idx, 2'b00};
        wb_dat_w = wdat;
        @(negedge aclk);
        while (!wb_ack) begin
            @(negedge aclk);
        end
        rdat   = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input logic [3:0] idx, input logic [31:0] val);
        logic [31:0] unused;
        bus_cycle(1'b1, idx, val, unused);
    endtask

    task automatic read_expect(input logic [3:0] idx, input logic [31:0] exp, input string name);
        logic [31:0] r;
        bus_cycle(1'b0, idx, '0, r);
        check_eq(name, r, exp);
    endtask

    function automatic int clamp_beats(input int w);
        if (w == 0) begin
            return 1;
        end
        return (w > MAX_BEATS) ? MAX_BEATS : w;
    endfunction

    task automatic put_be(input logic [63:0] v, input int n);
        for (int i = n - 1; i >= 0; i--) begin
            frame.push_back(v[8*i +: 8]);
        end
    endtask

    // Expected frame bytes without the FCS
    task automatic build_frame(input logic [23:0] psn);
        frame.delete();
        put_be(m_dst_mac, 6);
        put_be(m_src_mac, 6);
        put_be(16'h0800, 2);
        put_be(16'h4500, 2);
        put_be(44 + 8 * m_pb, 2);
        put_be(32'h0, 4);
        put_be(16'h4011, 2); // TTL 64, UDP
        put_be(16'h0, 2);
        put_be(m_src_ip, 4);
        put_be(m_dst_ip, 4);
        put_be(16'hC000, 2);
        put_be(16'd4791, 2);
        put_be(24 + 8 * m_pb, 2);
        put_be(16'h0, 2);
        put_be(32'h0400FFFF, 4);
        put_be({8'h00, m_qp}, 4);
        put_be({8'h00, psn}, 4);
        put_be(16'h0, 2);
        for (int k = 0; k < 8 * m_pb; k++) begin
            frame.push_back(psn[7:0] + 8'(k));
        end
    endtask

    function automatic logic [31:0] frame_crc();
        logic [31:0] c;
        c = 32'hFFFFFFFF;
        foreach (frame[k]) begin
            for (int b = 0; b < 8; b++) begin
                if (c[0] ^ frame[k][b]) begin
                    c = (c >> 1) ^ 32'hEDB88320;
                end else begin
                    c = c >> 1;
                end
            end
        end
        return ~c;
    endfunction

    task automatic wait_beats(input int n);
        while (rx_q.size() < n) begin
            @(negedge aclk);
        end
    endtask

    task automatic check_packet(input logic [23:0] psn);
        int          nb;
        logic [72:0] beat;
        logic [63:0] exp;
        logic [31:0] crc;
        build_frame(psn);
        crc = frame_crc();
        nb  = frame.size() / 8;
        wait_beats(nb + 1);
        for (int j = 0; j < nb; j++) begin
            beat = rx_q.pop_front();
            for (int i = 0; i < 8; i++) begin
                exp[8*i +: 8] = frame[8*j + i];
            end
            check_eq("o_tx_tdata", beat[63:0], exp);
            check_eq("o_tx_tkeep", beat[71:64], 8'hFF);
            check_eq("o_tx_tlast", beat[72], 1'b0);
        end
        beat = rx_q.pop_front();
        check_eq("o_tx_tdata (FCS)", beat[31:0], crc);
        check_eq("o_tx_tkeep (FCS)", beat[71:64], 8'h0F);
        check_eq("o_tx_tlast (FCS)", beat[72], 1'b1);
    endtask

    task automatic set_fields(input logic [47:0] smac, input logic [47:0] dmac,
                              input logic [31:0] sip, input logic [31:0] dip,
                              input logic [23:0] qp);
        wb_write(REG_SRC_MAC_LO, smac[31:0]);
        wb_write(REG_SRC_MAC_HI, {16'h0, smac[47:32]});
        wb_write(REG_DST_MAC_LO, dmac[31:0]);
        wb_write(REG_DST_MAC_HI, {16'h0, dmac[47:32]});
        wb_write(REG_SRC_IP, sip);
        wb_write(REG_DST_IP, dip);
        wb_write(REG_DEST_QP, {8'h0, qp});
        m_src_mac = smac;
        m_dst_mac = dmac;
        m_src_ip  = sip;
        m_dst_ip  = dip;
        m_qp      = qp;
    endtask

    task automatic set_run(input logic [23:0] psn, input int pb_w, input int cnt);
        wb_write(REG_START_PSN, {8'h0, psn});
        wb_write(REG_PAYLOAD_BEATS, pb_w);
        wb_write(REG_PKT_COUNT, cnt);
        m_psn = psn;
        m_pb  = clamp_beats(pb_w);
    endtask

    task automatic collect_run(input int n);
        logic [31:0] st;
        logic [23:0] psn;
        for (int i = 0; i < n; i++) begin
            psn = m_psn + 24'(i);
            check_packet(psn);
        end
        st = 32'h1;
        while (st[0]) begin
            bus_cycle(1'b0, REG_STATUS, '0, st);
        end
        check_eq("STATUS.done", st[1], 1'b1);
        read_expect(REG_SENT_COUNT, n, "SENT_COUNT");
        check_eq("beats beyond expected packets", rx_q.size(), 0);
    endtask

    task automatic run_and_check(input int n);
        wb_write(REG_CTRL, 32'h1);
        collect_run(n);
    endtask

    task automatic reg_readback();
        logic [31:0] val;
        logic [31:0] mask;
        check_eq("o_tx_tvalid after reset", tx_tvalid, 1'b0);
        read_expect(REG_SENT_COUNT, 32'h0, "SENT_COUNT after reset");
        for (int idx = REG_SRC_MAC_LO; idx <= REG_PKT_COUNT; idx++) begin
            val  = (idx == REG_PAYLOAD_BEATS) ? 32'd5 : $random(seed);
            mask = 32'hFFFFFFFF;
            if (idx == REG_SRC_MAC_HI || idx == REG_DST_MAC_HI || idx >= REG_PAYLOAD_BEATS) begin
                mask = 32'h0000FFFF;
            end else if (idx == REG_DEST_QP || idx == REG_START_PSN) begin
                mask = 32'h00FFFFFF;
            end
            wb_write(idx[3:0], val);
            read_expect(idx[3:0], val & mask, $sformatf("register %0d readback", idx));
        end
    endtask

    task automatic one_packet();
        set_run(24'h000123, 3, 1);
        run_and_check(1);
    endtask

    task automatic psn_wrap();
        set_run(24'hFFFFFE, 2, 5); // PSN wraps after two packets
        run_and_check(5);
    endtask

    task automatic random_backpressure();
        rand_ready = 1'b1;
        set_run(24'h00ABCD, 16, 4);
        run_and_check(4);
        rand_ready = 1'b0;
    endtask

    task automatic payload_clamp();
        set_run(24'h000010, 0, 2);
        read_expect(REG_PAYLOAD_BEATS, 32'd1, "PAYLOAD_BEATS after write of 0");
        run_and_check(2);
        set_run(24'h000020, 40, 2);
        read_expect(REG_PAYLOAD_BEATS, 32'd16, "PAYLOAD_BEATS after write of 40");
        run_and_check(2);
    endtask

    task automatic busy_write_ignored();
        set_run(24'h000555, 4, 3);
        wb_write(REG_CTRL, 32'h1);
        wb_write(REG_DST_IP, 32'hDEADBEEF); // Lands while busy
        read_expect(REG_DST_IP, m_dst_ip, "DST_IP after busy write");
        collect_run(3);
    endtask

    initial begin
        seed       = 5240;
        cycle_cnt  = 0;
        rand_ready = 1'b0;
        aclk       = 1'b0;
        aresetn    = 1'b0;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = '0;
        wb_dat_w   = '0;
        tx_tready  = 1'b0;
        repeat (10) @(negedge aclk);
        aresetn = 1'b1;

        reg_readback();
        set_fields(48'h0A1B2C3D4E5F, 48'h102030405060, 32'hC0A80001, 32'hC0A80002, 24'h000011);
        one_packet();
        psn_wrap();
        random_backpressure();
        payload_clamp();
        busy_write_ignored();

        if (UUT.u_asserts.fail_cnt == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("%0d assertion failures during the run", UUT.u_asserts.fail_cnt);
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/roce_pktgen_asserts.sv ====
`default_nettype none

module roce_pktgen_asserts (
    input logic        aclk,
    input logic        aresetn,
    input logic        i_wb_cyc,
    input logic        i_wb_stb,
    input logic        o_wb_ack,
    input logic [63:0] o_tx_tdata,
    input logic [7:0]  o_tx_tkeep,
    input logic        o_tx_tvalid,
    input logic        o_tx_tlast,
    input logic        i_tx_tready
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_cnt = 0;

    a_ack_after_stb: assert property (@(posedge aclk) disable iff (!aresetn)
        o_wb_ack |-> $past(i_wb_cyc && i_wb_stb))
    else begin
        $error("Wishbone ack without a preceding strobe");
        fail_cnt++;
    end

    a_ack_single: assert property (@(posedge aclk) disable iff (!aresetn)
        o_wb_ack |=> !o_wb_ack)
    else begin
        $error("Wishbone ack high for two cycles");
        fail_cnt++;
    end

    // Output beat holds under back-pressure
    a_tx_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        o_tx_tvalid && !i_tx_tready |=> o_tx_tvalid && $stable(o_tx_tdata)
            && $stable(o_tx_tkeep) && $stable(o_tx_tlast))
    else begin
        $error("Output beat changed while stalled");
        fail_cnt++;
    end

    a_keep_nonzero: assert property (@(posedge aclk) disable iff (!aresetn)
        o_tx_tvalid |-> o_tx_tkeep != '0)
    else begin
        $error("Valid output beat with empty keep");
        fail_cnt++;
    end

endmodule

bind roce_pktgen_top roce_pktgen_asserts u_asserts (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .i_wb_cyc    (i_wb_cyc),
    .i_wb_stb    (i_wb_stb),
    .o_wb_ack    (o_wb_ack),
    .o_tx_tdata  (o_tx_tdata),
    .o_tx_tkeep  (o_tx_tkeep),
    .o_tx_tvalid (o_tx_tvalid),
    .o_tx_tlast  (o_tx_tlast),
    .i_tx_tready (i_tx_tready)
);

`default_nettype wire

// ==== hdl/roce_pktgen_top.sv ====
`default_nettype none

module roce_pktgen_top #(
    parameter int MAX_PAYLOAD_BEATS = 16
) (
    input  logic                       aclk,
    input  logic                       aresetn,
    input  logic                       i_wb_cyc,
    input  logic                       i_wb_stb,
    input  logic                       i_wb_we,
    input  logic [5:0]                 i_wb_adr,
    input  pktgen_cfg_pkg::reg_word_t  i_wb_dat,
    output pktgen_cfg_pkg::reg_word_t  o_wb_dat,
    output logic                       o_wb_ack,
    output pktgen_cfg_pkg::beat_data_t o_tx_tdata,
    output pktgen_cfg_pkg::beat_keep_t o_tx_tkeep,
    output logic                       o_tx_tvalid,
    output logic                       o_tx_tlast,
    input  logic                       i_tx_tready
);
    import roce_hdr_pkg::*;

    logic hdr_req;
    logic hdr_ack;
    logic pay_req;
    logic pay_ack;
    psn_t psn;

    pktgen_cfg_if  cfg ();
    beat_stream_if hdr_s ();
    beat_stream_if pay_s ();

    wb_cfg_regs #(
        .MAX_PAYLOAD_BEATS (MAX_PAYLOAD_BEATS)
    ) u_regs (
        .i_aclk    (aclk),
        .i_aresetn (aresetn),
        .i_wb_cyc  (i_wb_cyc),
        .i_wb_stb  (i_wb_stb),
        .i_wb_we   (i_wb_we),
        .i_wb_adr  (i_wb_adr),
        .i_wb_dat  (i_wb_dat),
        .o_wb_dat  (o_wb_dat),
        .o_wb_ack  (o_wb_ack),
        .cfg       (cfg.regs)
    );

    // Static fields are stable while busy
    roce_hdr_builder u_hdr (
        .aclk            (aclk),
        .aresetn         (aresetn),
        .i_req           (hdr_req),
        .o_ack           (hdr_ack),
        .i_psn           (psn),
        .i_payload_beats (cfg.payload_beats),
        .i_src_mac       (cfg.src_mac),
        .i_dst_mac       (cfg.dst_mac),
        .i_src_ip        (cfg.src_ip),
        .i_dst_ip        (cfg.dst_ip),
        .i_dest_qp       (cfg.dest_qp),
        .hdr_s           (hdr_s.source)
    );

    payload_gen #(
        .MAX_PAYLOAD_BEATS (MAX_PAYLOAD_BEATS)
    ) u_pay (
        .aclk            (aclk),
        .aresetn         (aresetn),
        .i_req           (pay_req),
        .o_ack           (pay_ack),
        .i_psn           (psn),
        .i_payload_beats (cfg.payload_beats),
        .pay_s           (pay_s.source)
    );

    frame_merge #(
        .MAX_PAYLOAD_BEATS (MAX_PAYLOAD_BEATS)
    ) u_merge (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .cfg         (cfg.gen),
        .o_hdr_req   (hdr_req),
        .i_hdr_ack   (hdr_ack),
        .o_pay_req   (pay_req),
        .i_pay_ack   (pay_ack),
        .o_psn       (psn),
        .hdr_s       (hdr_s.sink),
        .pay_s       (pay_s.sink),
        .o_tx_tdata  (o_tx_tdata),
        .o_tx_tkeep  (o_tx_tkeep),
        .o_tx_tvalid (o_tx_tvalid),
        .o_tx_tlast  (o_tx_tlast),
        .i_tx_tready (i_tx_tready)
    );

endmodule

`default_nettype wire

// ==== pkt_gen/frame_merge.sv ====
`default_nettype none

module frame_merge #(
    parameter int MAX_PAYLOAD_BEATS = 16
) (
    input  logic                       aclk,
    input  logic                       aresetn,
    pktgen_cfg_if.gen                  cfg,
    output logic                       o_hdr_req,
    input  logic                       i_hdr_ack,
    output logic                       o_pay_req,
    input  logic                       i_pay_ack,
    output roce_hdr_pkg::psn_t         o_psn,
    beat_stream_if.sink                hdr_s,
    beat_stream_if.sink                pay_s,
    output pktgen_cfg_pkg::beat_data_t o_tx_tdata,
    output pktgen_cfg_pkg::beat_keep_t o_tx_tkeep,
    output logic                       o_tx_tvalid,
    output logic                       o_tx_tlast,
    input  logic                       i_tx_tready
);
    import roce_hdr_pkg::*;
    import pktgen_cfg_pkg::*;

    localparam int PB_W = $clog2(MAX_PAYLOAD_BEATS + 1);

    typedef enum logic [2:0] {IDLE, HDR, PAY, CRC, DONE} state_t;

    state_t          state;
    logic [31:0]     crc;
    psn_t            next_psn;
    pkt_count_t      req_cnt;    // Requests issued
    pkt_count_t      pkt_idx;    // CRC beats loaded
    pkt_count_t      sent_q;
    logic [PB_W-1:0] pay_left;
    logic            out_ready;
    logic            hdr_take;
    logic            pay_take;
    logic            crc_load;
    logic            issue;
    logic            last_pkt;
    beat_data_t      in_data;
    beat_keep_t      in_keep;

    // Reflected CRC-32, lane 0 first, bit 0 of each byte first
    function automatic logic [31:0] crc_beat(input logic [31:0] c, input beat_data_t d);
        logic [31:0] r;
        r = c;
        for (int i = 0; i < 64; i++) begin
            r = (r >> 1) ^ ((r[0] ^ d[i]) ? CRC32_POLY_REFL : 32'h0);
        end
        return r;
    endfunction

    assign out_ready   = !o_tx_tvalid || i_tx_tready;
    assign hdr_s.ready = (state == HDR) && out_ready;
    assign pay_s.ready = (state == PAY) && out_ready;
    assign hdr_take    = hdr_s.valid && hdr_s.ready;
    assign pay_take    = pay_s.valid && pay_s.ready;
    // Last packet's CRC beat waits in the output register
    assign crc_load    = (state == CRC) && out_ready && !(o_tx_tvalid && o_tx_tlast);
    assign last_pkt    = (pkt_idx == cfg.pkt_count - 1'b1);
    assign issue       = cfg.busy && !o_hdr_req && !o_pay_req && (req_cnt != cfg.pkt_count);
    assign in_data     = hdr_take ? hdr_s.data : pay_s.data;
    assign in_keep     = hdr_take ? hdr_s.keep : pay_s.keep;

    assign cfg.busy       = (state == HDR) || (state == PAY) || (state == CRC);
    assign cfg.done       = (state == DONE);
    assign cfg.sent_count = sent_q;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state       <= IDLE;
            crc         <= CRC32_INIT;
            next_psn    <= '0;
            o_psn       <= '0;
            req_cnt     <= '0;
            pkt_idx     <= '0;
            sent_q      <= '0;
            pay_left    <= '0;
            o_hdr_req   <= 1'b0;
            o_pay_req   <= 1'b0;
            o_tx_tvalid <= 1'b0;
            o_tx_tlast  <= 1'b0;
        end else begin
            case (state)
                IDLE, DONE: begin
                    if (cfg.start) begin
                        state    <= (cfg.pkt_count == '0) ? DONE : HDR;
                        next_psn <= cfg.start_psn;
                        req_cnt  <= '0;
                        pkt_idx  <= '0;
                        sent_q   <= '0;
                        crc      <= CRC32_INIT;
                    end
                end
                HDR: begin
                    if (hdr_take) begin
                        crc <= crc_beat(crc, hdr_s.data);
                        if (hdr_s.last) begin
                            state    <= PAY;
                            pay_left <= cfg.payload_beats[PB_W-1:0];
                        end
                    end
                end
                PAY: begin
                    if (pay_take) begin
                        crc      <= crc_beat(crc, pay_s.data);
                        pay_left <= pay_left - 1'b1;
                        if (pay_left == 1) begin
                            state <= CRC;
                        end
                    end
                end
                CRC: begin
                    if (crc_load) begin
                        crc     <= CRC32_INIT;
                        pkt_idx <= pkt_idx + 1'b1;
                        if (!last_pkt) begin
                            state <= HDR; // Next header may already wait
                        end
                    end else if (o_tx_tvalid && o_tx_tlast && i_tx_tready) begin
                        state <= DONE;
                    end
                end
                default: state <= IDLE;
            endcase

            if (o_tx_tvalid && o_tx_tlast && i_tx_tready) begin
                sent_q <= sent_q + 1'b1;
            end

            // Builder requests run one packet ahead
            if (i_hdr_ack) begin
                o_hdr_req <= 1'b0;
            end
            if (i_pay_ack) begin
                o_pay_req <= 1'b0;
            end
            if (issue) begin
                o_hdr_req <= 1'b1;
                o_pay_req <= 1'b1;
                o_psn     <= next_psn;
                next_psn  <= next_psn + 1'b1;
                req_cnt   <= req_cnt + 1'b1;
            end

            if (hdr_take || pay_take || crc_load) begin
                o_tx_tvalid <= 1'b1;
                o_tx_tlast  <= crc_load;
            end else if (i_tx_tready) begin
                o_tx_tvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (hdr_take || pay_take) begin
            o_tx_tdata <= in_data;
            o_tx_tkeep <= in_keep;
        end else if (crc_load) begin
            o_tx_tdata <= {32'h0, ~crc}; // FCS, low byte in lane 0
            o_tx_tkeep <= 8'h0F;
        end
    end

endmodule

`default_nettype wire

// ==== pkt_gen/payload_gen.sv ====
`default_nettype none

module payload_gen #(
    parameter int MAX_PAYLOAD_BEATS = 16
) (
    input  logic                       aclk,
    input  logic                       aresetn,
    input  logic                       i_req,
    output logic                       o_ack,
    input  roce_hdr_pkg::psn_t         i_psn,
    input  pktgen_cfg_pkg::pkt_count_t i_payload_beats,
    beat_stream_if.source              pay_s
);
    localparam int PB_W = $clog2(MAX_PAYLOAD_BEATS + 1);

    logic            active;
    logic [PB_W-1:0] beats_left;
    logic [7:0]      seed;       // Byte value of lane 0

    assign o_ack       = i_req && !active;
    assign pay_s.valid = active;
    assign pay_s.keep  = '1;
    assign pay_s.last  = (beats_left == 1);

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            pay_s.data[8*i +: 8] = seed + 8'(i);
        end
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            active     <= 1'b0;
            beats_left <= '0;
        end else if (o_ack) begin
            active     <= 1'b1;
            beats_left <= i_payload_beats[PB_W-1:0];
        end else if (pay_s.valid && pay_s.ready) begin
            if (pay_s.last) begin
                active <= 1'b0;
            end
            beats_left <= beats_left - 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (o_ack) begin
            seed <= i_psn[7:0];
        end else if (pay_s.valid && pay_s.ready) begin
            seed <= seed + 8'd8;
        end
    end

endmodule

`default_nettype wire

// ==== pkt_gen/roce_hdr_builder.sv ====
`default_nettype none

module roce_hdr_builder (
    input  logic                       aclk,
    input  logic                       aresetn,
    input  logic                       i_req,
    output logic                       o_ack,
    input  roce_hdr_pkg::psn_t         i_psn,
    input  pktgen_cfg_pkg::pkt_count_t i_payload_beats,
    input  roce_hdr_pkg::mac_addr_t    i_src_mac,
    input  roce_hdr_pkg::mac_addr_t    i_dst_mac,
    input  roce_hdr_pkg::ipv4_addr_t   i_src_ip,
    input  roce_hdr_pkg::ipv4_addr_t   i_dst_ip,
    input  roce_hdr_pkg::qpn_t         i_dest_qp,
    beat_stream_if.source              hdr_s
);
    import roce_hdr_pkg::*;

    typedef enum logic {IDLE, EMIT} state_t;

    state_t                       state;
    logic [$clog2(HDR_BEATS)-1:0] beat_cnt;
    mac_addr_t                    src_mac_q;
    mac_addr_t                    dst_mac_q;
    ipv4_addr_t                   src_ip_q;
    ipv4_addr_t                   dst_ip_q;
    qpn_t                         qp_q;
    psn_t                         psn_q;
    logic [15:0]                  ip_len_q;
    logic [15:0]                  udp_len_q;
    logic [64*HDR_BEATS-1:0]      hdr_vec;

    // Byte 0 of the frame sits at the top
    assign hdr_vec = {dst_mac_q, src_mac_q, ETH_TYPE_IPV4,
                      8'h45, 8'h00, ip_len_q, 32'h0, IP_TTL, 8'd17, 16'h0,
                      src_ip_q, dst_ip_q,
                      UDP_SRC_PORT, ROCE_UDP_PORT, udp_len_q, 16'h0,
                      BTH_OP_SEND_ONLY, 8'h00, BTH_PKEY, 8'h00, qp_q, 8'h00, psn_q,
                      16'h0};

    assign o_ack       = i_req && (state == IDLE);
    assign hdr_s.valid = (state == EMIT);
    assign hdr_s.keep  = '1;
    assign hdr_s.last  = (beat_cnt == HDR_BEATS - 1);

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            hdr_s.data[8*i +: 8] = hdr_vec[$bits(hdr_vec) - 1 - 64*beat_cnt - 8*i -: 8];
        end
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state    <= IDLE;
            beat_cnt <= '0;
        end else if (o_ack) begin
            state    <= EMIT;
            beat_cnt <= '0;
        end else if (hdr_s.valid && hdr_s.ready) begin
            if (hdr_s.last) begin
                state <= IDLE;
            end
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (o_ack) begin
            src_mac_q <= i_src_mac;
            dst_mac_q <= i_dst_mac;
            src_ip_q  <= i_src_ip;
            dst_ip_q  <= i_dst_ip;
            qp_q      <= i_dest_qp;
            psn_q     <= i_psn;
            ip_len_q  <= HDR_LEN_FIXED + {i_payload_beats[12:0], 3'b000};
            udp_len_q <= UDP_LEN_FIXED + {i_payload_beats[12:0], 3'b000};
        end
    end

endmodule

`default_nettype wire

// ==== hdl/wb_cfg_regs.sv ====
`default_nettype none

module wb_cfg_regs #(
    parameter int MAX_PAYLOAD_BEATS = 16
) (
    input  logic                      i_aclk,
    input  logic                      i_aresetn,
    input  logic                      i_wb_cyc,
    input  logic                      i_wb_stb,
    input  logic                      i_wb_we,
    input  logic [5:0]                i_wb_adr,
    input  pktgen_cfg_pkg::reg_word_t i_wb_dat,
    output pktgen_cfg_pkg::reg_word_t o_wb_dat,
    output logic                      o_wb_ack,
    pktgen_cfg_if.regs                cfg
);
    import pktgen_cfg_pkg::*;

    reg_addr_t addr;
    logic      access;
    logic      wr_cfg;
    reg_word_t rd_word;
    reg_word_t beats_clamped;

    assign addr   = i_wb_adr[5:2];
    assign access = i_wb_cyc && i_wb_stb && !o_wb_ack; // One ack per strobe
    assign wr_cfg = access && i_wb_we && !cfg.busy;

    always_comb begin
        if (i_wb_dat == '0) begin
            beats_clamped = 32'd1;
        end else if (i_wb_dat > MAX_PAYLOAD_BEATS) begin
            beats_clamped = MAX_PAYLOAD_BEATS;
        end else begin
            beats_clamped = i_wb_dat;
        end
    end

    always_ff @(posedge i_aclk or negedge i_aresetn) begin
        if (!i_aresetn) begin
            o_wb_ack          <= 1'b0;
            cfg.start         <= 1'b0;
            cfg.src_mac       <= '0;
            cfg.dst_mac       <= '0;
            cfg.src_ip        <= '0;
            cfg.dst_ip        <= '0;
            cfg.dest_qp       <= '0;
            cfg.start_psn     <= '0;
            cfg.payload_beats <= 16'd1;
            cfg.pkt_count     <= '0;
        end else begin
            o_wb_ack  <= access;
            cfg.start <= access && i_wb_we && (addr == REG_CTRL) && i_wb_dat[0];
            if (wr_cfg) begin
                case (addr)
                    REG_SRC_MAC_LO:    cfg.src_mac[31:0]  <= i_wb_dat;
                    REG_SRC_MAC_HI:    cfg.src_mac[47:32] <= i_wb_dat[15:0];
                    REG_DST_MAC_LO:    cfg.dst_mac[31:0]  <= i_wb_dat;
                    REG_DST_MAC_HI:    cfg.dst_mac[47:32] <= i_wb_dat[15:0];
                    REG_SRC_IP:        cfg.src_ip         <= i_wb_dat;
                    REG_DST_IP:        cfg.dst_ip         <= i_wb_dat;
                    REG_DEST_QP:       cfg.dest_qp        <= i_wb_dat[23:0];
                    REG_START_PSN:     cfg.start_psn      <= i_wb_dat[23:0];
                    REG_PAYLOAD_BEATS: cfg.payload_beats  <= beats_clamped[15:0];
                    REG_PKT_COUNT:     cfg.pkt_count      <= i_wb_dat[15:0];
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        case (addr)
            REG_STATUS:        rd_word = {30'd0, cfg.done, cfg.busy};
            REG_SRC_MAC_LO:    rd_word = cfg.src_mac[31:0];
            REG_SRC_MAC_HI:    rd_word = {16'd0, cfg.src_mac[47:32]};
            REG_DST_MAC_LO:    rd_word = cfg.dst_mac[31:0];
            REG_DST_MAC_HI:    rd_word = {16'd0, cfg.dst_mac[47:32]};
            REG_SRC_IP:        rd_word = cfg.src_ip;
            REG_DST_IP:        rd_word = cfg.dst_ip;
            REG_DEST_QP:       rd_word = {8'd0, cfg.dest_qp};
            REG_START_PSN:     rd_word = {8'd0, cfg.start_psn};
            REG_PAYLOAD_BEATS: rd_word = {16'd0, cfg.payload_beats};
            REG_PKT_COUNT:     rd_word = {16'd0, cfg.pkt_count};
            REG_SENT_COUNT:    rd_word = {16'd0, cfg.sent_count};
            default:           rd_word = '0; // CTRL and holes read zero
        endcase
    end

    always_ff @(posedge i_aclk) begin
        if (access) begin
            o_wb_dat <= rd_word;
        end
    end

endmodule

`default_nettype wire

// ==== common/pktgen_cfg_if.sv ====
`default_nettype none

interface pktgen_cfg_if;
    import roce_hdr_pkg::*;
    import pktgen_cfg_pkg::*;

    mac_addr_t  src_mac;
    mac_addr_t  dst_mac;
    ipv4_addr_t src_ip;
    ipv4_addr_t dst_ip;
    qpn_t       dest_qp;
    psn_t       start_psn;
    pkt_count_t payload_beats;
    pkt_count_t pkt_count;
    logic       start;      // Single cycle
    logic       busy;
    logic       done;
    pkt_count_t sent_count;

    modport regs (output src_mac, dst_mac, src_ip, dst_ip, dest_qp, start_psn,
                  payload_beats, pkt_count, start, input busy, done, sent_count);
    modport gen (input start, start_psn, payload_beats, pkt_count,
                 output busy, done, sent_count);

endinterface

`default_nettype wire

// ==== common/beat_stream_if.sv ====
`default_nettype none

interface beat_stream_if;
    import pktgen_cfg_pkg::*;

    beat_data_t data;
    beat_keep_t keep;
    logic       last;
    logic       valid;
    logic       ready;

    modport source (output data, keep, last, valid, input ready);
    modport sink (input data, keep, last, valid, output ready);

endinterface

`default_nettype wire

// ==== common/pktgen_cfg_pkg.sv ====
`default_nettype none

package pktgen_cfg_pkg;

    typedef logic [63:0] beat_data_t;
    typedef logic [7:0]  beat_keep_t; // Lane 0 is the earliest byte
    typedef logic [31:0] reg_word_t;
    typedef logic [3:0]  reg_addr_t;
    typedef logic [15:0] pkt_count_t;

    localparam reg_addr_t REG_CTRL          = 4'd0;
    localparam reg_addr_t REG_STATUS        = 4'd1;
    localparam reg_addr_t REG_SRC_MAC_LO    = 4'd2;
    localparam reg_addr_t REG_SRC_MAC_HI    = 4'd3;
    localparam reg_addr_t REG_DST_MAC_LO    = 4'd4;
    localparam reg_addr_t REG_DST_MAC_HI    = 4'd5;
    localparam reg_addr_t REG_SRC_IP        = 4'd6;
    localparam reg_addr_t REG_DST_IP        = 4'd7;
    localparam reg_addr_t REG_DEST_QP       = 4'd8;
    localparam reg_addr_t REG_START_PSN     = 4'd9;
    localparam reg_addr_t REG_PAYLOAD_BEATS = 4'd10;
    localparam reg_addr_t REG_PKT_COUNT     = 4'd11;
    localparam reg_addr_t REG_SENT_COUNT    = 4'd12;

    localparam logic [31:0] CRC32_POLY_REFL = 32'hEDB88320;
    localparam logic [31:0] CRC32_INIT      = 32'hFFFFFFFF;

endpackage

`default_nettype wire

// ==== common/roce_hdr_pkg.sv ====
`default_nettype none

package roce_hdr_pkg;

    typedef logic [47:0] mac_addr_t;
    typedef logic [31:0] ipv4_addr_t;
    typedef logic [23:0] qpn_t;
    typedef logic [23:0] psn_t;

    localparam logic [15:0] ETH_TYPE_IPV4 = 16'h0800;
    localparam logic [15:0] ROCE_UDP_PORT = 16'd4791;
    localparam logic [15:0] UDP_SRC_PORT  = 16'hC000;
    localparam logic [7:0]  IP_TTL        = 8'd64;

    localparam logic [7:0]  BTH_OP_SEND_ONLY = 8'h04;
    localparam logic [15:0] BTH_PKEY         = 16'hFFFF;

    localparam int HDR_BEATS = 7; // 54 header bytes plus 2 pad bytes

    // IPv4 + UDP + BTH + ICRC on top of the payload
    localparam logic [15:0] HDR_LEN_FIXED = 16'd44;
    localparam logic [15:0] UDP_LEN_FIXED = 16'd24;

endpackage

`default_nettype wire
